// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = ppu_tb
FILELIST = src.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = test passed
RUN_ARGS = +verilator+error+limit+100

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "simulation did not pass"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/ppu_asserts.sv ====
`timescale 1ns/1ps

module ppu_asserts import ppu_ctrl_pkg::*; (
    input logic              clk,
    input logic              arst_n,
    input logic              instr_ready,
    input logic              out_valid,
    input logic [ctrl_w-1:0] out_ctrl,
    input logic [4:0]        out_dest,
    input logic [31:0]       out_pc,
    input logic              out_ready
);

    // output slot offered but not taken
    logic stalled;
    assign stalled = out_valid & ~out_ready;

    // nothing offered while reset is held
    reset_quiet: assert property (@(posedge clk) !arst_n |-> !out_valid)
        else $error("out_valid high while in reset");

    // a waiting output keeps valid and payload until taken
    hold_on_stall: assert property (@(posedge clk) disable iff (!arst_n)
        stalled |=> out_valid && $stable(out_ctrl) && $stable(out_dest) && $stable(out_pc))
        else $error("output changed during a stall");

    // input side closes exactly while the output waits
    ready_vs_stall: assert property (@(posedge clk) disable iff (!arst_n)
        instr_ready == !stalled)
        else $error("instr_ready does not match the stall condition");

endmodule

bind ppu_pipeline_top ppu_asserts asserts_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .instr_ready (instr_ready),
    .out_valid   (out_valid),
    .out_ctrl    (out_ctrl),
    .out_dest    (out_dest),
    .out_pc      (out_pc),
    .out_ready   (out_ready)
);

// ==== bench/ppu_stim.txt ====
# test  instr     ctrl   dest  (all hex except the test number)
# grouped by test in run order, so the pc of each line is 4 times its position
1 24010001 00a00 01
1 00211021 00200 02
2 00221821 00200 03
2 00a62023 04200 04
2 01093824 08200 07
2 016c5025 0c200 0a
2 01cf682a 10200 0d
2 02110018 14003 00
2 00009010 1a200 12
2 00009812 1aa00 13
3 24341234 00a00 14
3 3055ff00 09200 15
3 3c16abcd 19a00 16
3 8fb70008 00e48 17
3 83b8fffc 00e60 18
3 90990003 00e40 19
3 afa50010 00858 00
3 a0e60001 00850 00
3 10220010 04180 00
3 1464fffe 04180 00
4 00430821 00200 01
4 8d280000 00e48 08
4 ad280004 00858 00
4 0101102a 10200 02
4 3c038000 19a00 03
4 00640018 14003 00
4 90a60007 00e40 06
4 00c53823 04200 07
5 fc421234 00000 00
5 0022183f 00000 00
5 00c72825 0c200 05
6 00220825 0c200 01
6 00231024 08200 02
6 24630004 00a00 03
6 80640002 00e60 04

// ==== bench/ppu_tb.sv ====
`timescale 1ns/1ps

module ppu_tb
    import ppu_isa_pkg::*, ppu_ctrl_pkg::*;
();

    localparam int max_entries  = 64;
    localparam int accept_limit = 200;
    localparam int drain_limit  = 200;
    // valid shows after edge k+3 and is taken at the edge after that
    localparam int xfer_edges   = 4;

    logic               clk = 1'b0;
    logic               arst_n;
    logic               instr_valid;
    logic [instr_w-1:0] instr;
    logic               instr_ready;
    logic               out_valid;
    logic [ctrl_w-1:0]  out_ctrl;
    logic [reg_w-1:0]   out_dest;
    logic [pc_w-1:0]    out_pc;
    logic               out_ready = 1'b1;

    // stim table with one slot per file line
    int                 test_no   [max_entries];
    logic [instr_w-1:0] instr_mem [max_entries];
    logic [ctrl_w-1:0]  exp_ctrl  [max_entries];
    logic [reg_w-1:0]   exp_dest  [max_entries];
    // edge count seen just before the accepting edge
    int                 acc_edge  [max_entries];
    int                 n_entries = 0;

    int  edge_cnt  = 0;
    int  sent      = 0;
    int  out_idx   = 0;
    int  err_cnt   = 0;
    int  tests_bad = 0;
    bit  aborted   = 1'b0;
    bit  drop_ready    = 1'b0;
    // drop enable as seen at the clock edge
    bit  drop_now      = 1'b0;
    bit  check_latency = 1'b0;
    logic [31:0] gap_state   = 32'h6ce;
    logic [31:0] ready_state = 32'h6ce;

    // last stalled cycle's outputs
    bit                was_stalled = 1'b0;
    logic [ctrl_w-1:0] held_ctrl;
    logic [reg_w-1:0]  held_dest;
    logic [pc_w-1:0]   held_pc;

    string names [6] = '{"reset state", "r-type decode", "i-type and memory decode",
                         "back-pressure and bubbles", "unknown encodings", "latency"};

    ppu_pipeline_top dut_i (.*);

    always #5 clk = ~clk;

    always @(posedge clk) edge_cnt <= edge_cnt + 1;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // consumer side drops ready at random only while enabled
    always @(posedge clk) begin
        drop_now = drop_ready;
        #1;
        if (drop_now) begin
            ready_state = lcg_next(ready_state);
            out_ready   = (ready_state[25:24] != 2'b00);
        end else begin
            out_ready = 1'b1;
        end
    end

    // scoreboard samples mid-cycle where everything is settled
    always @(negedge clk) begin
        if (!arst_n) begin
            if (out_valid) begin
                $display("mismatch out_valid: got %h, expected %h", out_valid, 1'b0);
                err_cnt++;
            end
        end else begin
            if (instr_ready !== !(out_valid && !out_ready)) begin
                $display("mismatch instr_ready: got %h, expected %h", instr_ready,
                         !(out_valid && !out_ready));
                err_cnt++;
            end
            if (was_stalled && (!out_valid || out_ctrl !== held_ctrl ||
                                out_dest !== held_dest || out_pc !== held_pc)) begin
                $display("error: outputs changed while stalled at pc %h", held_pc);
                err_cnt++;
            end
            was_stalled = out_valid && !out_ready;
            held_ctrl   = out_ctrl;
            held_dest   = out_dest;
            held_pc     = out_pc;
            if (out_valid && out_ready) begin
                if (out_idx >= n_entries) begin
                    $display("error: output at pc %h with nothing left to expect", out_pc);
                    err_cnt++;
                end else begin
                    if (out_ctrl !== exp_ctrl[out_idx]) begin
                        $display("mismatch out_ctrl: got %h, expected %h", out_ctrl,
                                 exp_ctrl[out_idx]);
                        err_cnt++;
                    end
                    if (out_dest !== exp_dest[out_idx]) begin
                        $display("mismatch out_dest: got %h, expected %h", out_dest,
                                 exp_dest[out_idx]);
                        err_cnt++;
                    end
                    // pc steps by 4 per accepted word from 0
                    if (out_pc !== 32'(4 * out_idx)) begin
                        $display("mismatch out_pc: got %h, expected %h", out_pc, 4 * out_idx);
                        err_cnt++;
                    end
                    if (check_latency && edge_cnt - acc_edge[out_idx] != xfer_edges) begin
                        $display("mismatch latency edges: got %h, expected %h",
                                 edge_cnt - acc_edge[out_idx], xfer_edges);
                        err_cnt++;
                    end
                end
                out_idx++;
            end
        end
    end

    // sends one test's words in file order
    task automatic drive_test(input int t, input bit gaps);
        int i;
        int tries;
        bit taken;
        for (i = 0; i < n_entries; i++) begin
            if (test_no[i] == t && !aborted) begin
                // idle cycles before the word
                gap_state = lcg_next(gap_state);
                while (gaps && gap_state[27:26] == 2'b00) begin
                    instr_valid = 1'b0;
                    @(posedge clk);
                    #1;
                    gap_state = lcg_next(gap_state);
                end
                instr_valid = 1'b1;
                instr       = instr_mem[i];
                taken       = 1'b0;
                tries       = 0;
                // hold the word until the handshake fires
                while (!taken && !aborted) begin
                    @(negedge clk);
                    if (instr_ready) begin
                        taken       = 1'b1;
                        acc_edge[i] = edge_cnt;
                    end
                    @(posedge clk);
                    #1;
                    tries++;
                    if (!taken && tries >= accept_limit) begin
                        $display("error: word %0d not accepted in %0d cycles", i, accept_limit);
                        err_cnt++;
                        aborted = 1'b1;
                    end
                end
                sent++;
            end
        end
        instr_valid = 1'b0;
    endtask

    // until every sent word has come out
    task automatic wait_drain();
        int tries;
        tries = 0;
        while (out_idx < sent && !aborted) begin
            @(posedge clk);
            #1;
            tries++;
            if (tries >= drain_limit) begin
                $display("error: %0d outputs missing after %0d cycles", sent - out_idx,
                         drain_limit);
                err_cnt++;
                aborted = 1'b1;
            end
        end
    endtask

    initial begin
        int fd;
        int t;
        int start_err;
        int t_rd;
        string line;
        logic [31:0] w_rd;
        logic [31:0] c_rd;
        logic [31:0] d_rd;
        arst_n      = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        fd = $fopen("bench/ppu_stim.txt", "r");
        if (fd == 0) begin
            $display("error: cannot open bench/ppu_stim.txt");
            err_cnt++;
            aborted = 1'b1;
        end else begin
            // comment lines fail the scan and drop out
            while (!$feof(fd) && n_entries < max_entries) begin
                if ($fgets(line, fd) != 0 &&
                    $sscanf(line, "%d %h %h %h", t_rd, w_rd, c_rd, d_rd) == 4) begin
                    test_no[n_entries]   = t_rd;
                    instr_mem[n_entries] = w_rd;
                    exp_ctrl[n_entries]  = c_rd[ctrl_w-1:0];
                    exp_dest[n_entries]  = d_rd[reg_w-1:0];
                    n_entries++;
                end
            end
            $fclose(fd);
        end
        repeat (16) @(posedge clk);
        #1 arst_n = 1'b1;
        for (t = 1; t <= 6; t++) begin
            start_err = err_cnt;
            if (t == 1) begin
                // idle pipe with the input open before the first word
                @(negedge clk);
                if (out_valid !== 1'b0) begin
                    $display("mismatch out_valid: got %h, expected %h", out_valid, 1'b0);
                    err_cnt++;
                end
                if (instr_ready !== 1'b1) begin
                    $display("mismatch instr_ready: got %h, expected %h", instr_ready, 1'b1);
                    err_cnt++;
                end
                @(posedge clk);
                #1;
            end
            drop_ready    = (t == 4);
            check_latency = (t == 6);
            drive_test(t, t == 4);
            wait_drain();
            drop_ready    = 1'b0;
            check_latency = 1'b0;
            if (err_cnt != start_err) begin
                tests_bad++;
            end
            $display("test %0d %s: %0d errors", t, names[t-1], err_cnt - start_err);
        end
        // no late output may follow the last word
        repeat (8) @(posedge clk);
        $display("tests 6, clean %0d, with errors %0d, errors %0d, outputs %0d of %0d",
                 6 - tests_bad, tests_bad, err_cnt, out_idx, n_entries);
        if (err_cnt == 0 && !aborted) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== src.f ====
src/ppu_isa_pkg.sv
src/ppu_ctrl_pkg.sv
src/fetch_unit.sv
src/control_unit.sv
src/stage_chain.sv
src/ppu_pipeline_top.sv
bench/ppu_asserts.sv
bench/ppu_tb.sv

// ==== src/control_unit.sv ====
`timescale 1ns/1ps

module control_unit import ppu_isa_pkg::*, ppu_ctrl_pkg::*; (
    input  instr_u             id_instr,
    output logic [ctrl_w-1:0]  dec_ctrl,
    output logic [reg_w-1:0]   dec_dest
);

    always_comb begin
        // unknown encodings fall through as all zero
        dec_ctrl = '0;
        dec_dest = '0;

        case (id_instr.r_view.opcode)
            op_special: begin
                // register format, result goes to rd
                dec_dest = id_instr.r_view.rd;
                dec_ctrl[src_op_msb -: src_op_w] = src_reg;
                dec_ctrl[rf_enable_bit]          = 1'b1;
                case (id_instr.r_view.funct)
                    fn_addu: dec_ctrl[alu_op_msb -: alu_op_w] = alu_add;
                    fn_subu: dec_ctrl[alu_op_msb -: alu_op_w] = alu_sub;
                    fn_and:  dec_ctrl[alu_op_msb -: alu_op_w] = alu_and;
                    fn_or:   dec_ctrl[alu_op_msb -: alu_op_w] = alu_or;
                    fn_slt:  dec_ctrl[alu_op_msb -: alu_op_w] = alu_slt;
                    fn_mult: begin
                        // product lands in hi/lo only
                        dec_ctrl[alu_op_msb -: alu_op_w] = alu_mul;
                        dec_ctrl[rf_enable_bit]          = 1'b0;
                        dec_ctrl[hi_enable_bit]          = 1'b1;
                        dec_ctrl[lo_enable_bit]          = 1'b1;
                    end
                    fn_mfhi: begin
                        dec_ctrl[alu_op_msb -: alu_op_w] = alu_passb;
                        dec_ctrl[src_op_msb -: src_op_w] = src_hi;
                    end
                    fn_mflo: begin
                        dec_ctrl[alu_op_msb -: alu_op_w] = alu_passb;
                        dec_ctrl[src_op_msb -: src_op_w] = src_lo;
                    end
                    default: begin
                        // undefined funct
                        dec_ctrl = '0;
                        dec_dest = '0;
                    end
                endcase
            end
            op_addiu, op_andi, op_lui: begin
                // immediate alu ops write rt
                dec_dest                = id_instr.i_view.rt;
                dec_ctrl[rf_enable_bit] = 1'b1;
                if (id_instr.i_view.opcode == op_addiu) begin
                    dec_ctrl[alu_op_msb -: alu_op_w] = alu_add;
                    dec_ctrl[src_op_msb -: src_op_w] = src_imm_se;
                end else if (id_instr.i_view.opcode == op_andi) begin
                    dec_ctrl[alu_op_msb -: alu_op_w] = alu_and;
                    dec_ctrl[src_op_msb -: src_op_w] = src_imm_ze;
                end else begin
                    // lui shifts the immediate to the upper half
                    dec_ctrl[alu_op_msb -: alu_op_w] = alu_passb;
                    dec_ctrl[src_op_msb -: src_op_w] = src_imm_hi;
                end
            end
            op_lw, op_lb, op_lbu: begin
                // address is base plus signed offset
                dec_dest                         = id_instr.i_view.rt;
                dec_ctrl[alu_op_msb -: alu_op_w] = alu_add;
                dec_ctrl[src_op_msb -: src_op_w] = src_imm_se;
                dec_ctrl[load_instr_bit]         = 1'b1;
                dec_ctrl[rf_enable_bit]          = 1'b1;
                dec_ctrl[mem_enable_bit]         = 1'b1;
                dec_ctrl[mem_size_msb -: mem_size_w] =
                    (id_instr.i_view.opcode == op_lw) ? size_word : size_byte;
                // only lb extends the loaded byte's sign
                dec_ctrl[mem_se_bit] = (id_instr.i_view.opcode == op_lb);
            end
            op_sw, op_sb: begin
                // stores leave the register file alone, dest stays 0
                dec_ctrl[alu_op_msb -: alu_op_w] = alu_add;
                dec_ctrl[src_op_msb -: src_op_w] = src_imm_se;
                dec_ctrl[mem_enable_bit]         = 1'b1;
                dec_ctrl[mem_rw_bit]             = 1'b1;
                dec_ctrl[mem_size_msb -: mem_size_w] =
                    (id_instr.i_view.opcode == op_sw) ? size_word : size_byte;
            end
            op_beq, op_bne: begin
                // compare by subtraction
                dec_ctrl[alu_op_msb -: alu_op_w] = alu_sub;
                dec_ctrl[src_op_msb -: src_op_w] = src_reg;
                dec_ctrl[branch_bit]             = 1'b1;
                dec_ctrl[ta_instr_bit]           = 1'b1;
            end
            default: begin
                // undefined opcode keeps the zero word
            end
        endcase
    end

endmodule

// ==== src/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit import ppu_isa_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            instr_valid,
    input  instr_u          instr,
    output logic            instr_ready,
    input  logic            stall,
    output logic            id_valid,
    output instr_u          id_instr,
    output logic [pc_w-1:0] id_pc
);

    // pc of the next word to accept
    logic [pc_w-1:0] pc;
    // one step ahead of pc
    logic [pc_w-1:0] npc;
    // handshake fires this cycle
    logic            accept;

    // room for a new word whenever the chain moves
    assign instr_ready = ~stall;
    assign accept      = instr_valid & instr_ready;

    // pc, npc and the if/id valid bit
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc       <= '0;
            npc      <= pc_step;
            id_valid <= 1'b0;
        end else if (!stall) begin
            // bubble moves in when nothing is accepted
            id_valid <= accept;
            if (accept) begin
                // sequential only, no redirect
                pc  <= npc;
                npc <= npc + pc_step;
            end
        end
    end

    // if/id payload
    always_ff @(posedge clk) begin
        if (accept) begin
            id_instr <= instr;
            // word is tagged with the pc before the step
            id_pc    <= pc;
        end
    end

endmodule

// ==== src/ppu_ctrl_pkg.sv ====
package ppu_ctrl_pkg;

    // full control word width
    localparam int ctrl_w = 17;

    // multi-bit fields, msb position and width
    localparam int alu_op_msb   = 16;
    localparam int alu_op_w     = 3;
    localparam int src_op_msb   = 13;
    localparam int src_op_w     = 3;
    localparam int mem_size_msb = 3;
    localparam int mem_size_w   = 2;

    // single-bit flags
    localparam int load_instr_bit = 10;
    localparam int rf_enable_bit  = 9;
    localparam int branch_bit     = 8;
    localparam int ta_instr_bit   = 7;
    localparam int mem_enable_bit = 6;
    localparam int mem_se_bit     = 5;
    // 1 means write
    localparam int mem_rw_bit     = 4;
    localparam int hi_enable_bit  = 1;
    localparam int lo_enable_bit  = 0;

    // memory access sizes
    localparam logic [mem_size_w-1:0] size_byte = 2'd0;
    localparam logic [mem_size_w-1:0] size_word = 2'd2;

    // alu operations
    localparam logic [alu_op_w-1:0] alu_add   = 3'd0;
    localparam logic [alu_op_w-1:0] alu_sub   = 3'd1;
    localparam logic [alu_op_w-1:0] alu_and   = 3'd2;
    localparam logic [alu_op_w-1:0] alu_or    = 3'd3;
    localparam logic [alu_op_w-1:0] alu_slt   = 3'd4;
    localparam logic [alu_op_w-1:0] alu_mul   = 3'd5;
    localparam logic [alu_op_w-1:0] alu_passb = 3'd6;

    // second operand source
    localparam logic [src_op_w-1:0] src_reg    = 3'd0;
    localparam logic [src_op_w-1:0] src_imm_se = 3'd1;
    localparam logic [src_op_w-1:0] src_imm_ze = 3'd2;
    localparam logic [src_op_w-1:0] src_imm_hi = 3'd3;
    localparam logic [src_op_w-1:0] src_hi     = 3'd4;
    localparam logic [src_op_w-1:0] src_lo     = 3'd5;

endpackage

// ==== src/ppu_isa_pkg.sv ====
package ppu_isa_pkg;

    // basic widths of the instruction set
    localparam int instr_w = 32;
    localparam int pc_w    = 32;
    localparam int reg_w   = 5;

    // opcode and funct fields
    localparam int op_w  = 6;
    localparam int fn_w  = 6;
    // immediate fills what the i-format leaves over
    localparam int imm_w = instr_w - op_w - 2 * reg_w;

    // byte address step between instructions
    localparam logic [pc_w-1:0] pc_step = 32'd4;

    // primary opcodes
    localparam logic [op_w-1:0] op_special = 6'h00;
    localparam logic [op_w-1:0] op_beq     = 6'h04;
    localparam logic [op_w-1:0] op_bne     = 6'h05;
    localparam logic [op_w-1:0] op_addiu   = 6'h09;
    localparam logic [op_w-1:0] op_andi    = 6'h0c;
    localparam logic [op_w-1:0] op_lui     = 6'h0f;
    localparam logic [op_w-1:0] op_lb      = 6'h20;
    localparam logic [op_w-1:0] op_lw      = 6'h23;
    localparam logic [op_w-1:0] op_lbu     = 6'h24;
    localparam logic [op_w-1:0] op_sb      = 6'h28;
    localparam logic [op_w-1:0] op_sw      = 6'h2b;

    // function codes under op_special
    localparam logic [fn_w-1:0] fn_mfhi = 6'h10;
    localparam logic [fn_w-1:0] fn_mflo = 6'h12;
    localparam logic [fn_w-1:0] fn_mult = 6'h18;
    localparam logic [fn_w-1:0] fn_addu = 6'h21;
    localparam logic [fn_w-1:0] fn_subu = 6'h23;
    localparam logic [fn_w-1:0] fn_and  = 6'h24;
    localparam logic [fn_w-1:0] fn_or   = 6'h25;
    localparam logic [fn_w-1:0] fn_slt  = 6'h2a;

    // register format
    typedef struct packed {
        logic [op_w-1:0]  opcode;
        logic [reg_w-1:0] rs;
        logic [reg_w-1:0] rt;
        logic [reg_w-1:0] rd;
        logic [reg_w-1:0] shamt;
        logic [fn_w-1:0]  funct;
    } r_fmt_t;

    // immediate format, also loads, stores and branches
    typedef struct packed {
        logic [op_w-1:0]  opcode;
        logic [reg_w-1:0] rs;
        logic [reg_w-1:0] rt;
        logic [imm_w-1:0] imm;
    } i_fmt_t;

    // one word, two readings picked by the opcode
    typedef union packed {
        r_fmt_t r_view;
        i_fmt_t i_view;
    } instr_u;

endpackage

// ==== src/ppu_pipeline_top.sv ====
`timescale 1ns/1ps

module ppu_pipeline_top import ppu_isa_pkg::*, ppu_ctrl_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,
    // instruction stream in
    input  logic              instr_valid,
    input  instr_u            instr,
    output logic              instr_ready,
    // decoded stream out
    output logic              out_valid,
    output logic [ctrl_w-1:0] out_ctrl,
    output logic [reg_w-1:0]  out_dest,
    output logic [pc_w-1:0]   out_pc,
    input  logic              out_ready
);

    // if/id contents
    logic              id_valid;
    instr_u            id_instr;
    logic [pc_w-1:0]   id_pc;
    // decoder result
    logic [ctrl_w-1:0] dec_ctrl;
    logic [reg_w-1:0]  dec_dest;
    // back-pressure from the output side
    logic              stall;

    fetch_unit fetch_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_ready (instr_ready),
        .stall       (stall),
        .id_valid    (id_valid),
        .id_instr    (id_instr),
        .id_pc       (id_pc)
    );

    // decode sits between if/id and id/ex
    control_unit ctrl_i (
        .id_instr (id_instr),
        .dec_ctrl (dec_ctrl),
        .dec_dest (dec_dest)
    );

    stage_chain chain_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .id_valid  (id_valid),
        .dec_ctrl  (dec_ctrl),
        .dec_dest  (dec_dest),
        .id_pc     (id_pc),
        .stall     (stall),
        .out_valid (out_valid),
        .out_ctrl  (out_ctrl),
        .out_dest  (out_dest),
        .out_pc    (out_pc),
        .out_ready (out_ready)
    );

endmodule

// ==== src/stage_chain.sv ====
`timescale 1ns/1ps

module stage_chain import ppu_ctrl_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              id_valid,
    input  logic [ctrl_w-1:0] dec_ctrl,
    input  logic [4:0]        dec_dest,
    input  logic [31:0]       id_pc,
    output logic              stall,
    output logic              out_valid,
    output logic [ctrl_w-1:0] out_ctrl,
    output logic [4:0]        out_dest,
    output logic [31:0]       out_pc,
    input  logic              out_ready
);

    // id/ex
    logic              ex_valid;
    logic [ctrl_w-1:0] ex_ctrl;
    logic [4:0]        ex_dest;
    logic [31:0]       ex_pc;

    // ex/mem
    logic              mem_valid;
    logic [ctrl_w-1:0] mem_ctrl;
    logic [4:0]        mem_dest;
    logic [31:0]       mem_pc;

    // mem/wb
    logic              wb_valid;
    logic [ctrl_w-1:0] wb_ctrl;
    logic [4:0]        wb_dest;
    logic [31:0]       wb_pc;

    // whole pipe freezes while the offered slot waits
    assign stall = wb_valid & ~out_ready;

    // valid bits mark real slots vs bubbles
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_valid  <= 1'b0;
            mem_valid <= 1'b0;
            wb_valid  <= 1'b0;
        end else if (!stall) begin
            ex_valid  <= id_valid;
            mem_valid <= ex_valid;
            wb_valid  <= mem_valid;
        end
    end

    // payload shifts along with the valid bits
    always_ff @(posedge clk) begin
        if (!stall) begin
            ex_ctrl  <= dec_ctrl;
            ex_dest  <= dec_dest;
            ex_pc    <= id_pc;
            mem_ctrl <= ex_ctrl;
            mem_dest <= ex_dest;
            mem_pc   <= ex_pc;
            wb_ctrl  <= mem_ctrl;
            wb_dest  <= mem_dest;
            wb_pc    <= mem_pc;
        end
    end

    // mem/wb is what the consumer sees
    assign out_valid = wb_valid;
    assign out_ctrl  = wb_ctrl;
    assign out_dest  = wb_dest;
    assign out_pc    = wb_pc;

endmodule
